// File: design/periph_pkg.sv
// Peripheral package
// Address map, bus widths, register offsets and response codes shared by the RTL

package periph_pkg;

    // ------------------------------------------------------------------------
    // Bus
    // ------------------------------------------------------------------------
    localparam int AddrWidth   = 16;
    localparam int DataWidth   = 32;
    localparam int OffsetWidth = 12;

    // Region select bits and region numbers
    localparam int RegionMsb   = 15;
    localparam int RegionLsb   = 12;
    localparam int RegionIrq   = 0;
    localparam int RegionTimer = 1;
    localparam int RegionGpio  = 2;

    localparam logic [1:0]           RespOkay   = 2'b00;
    localparam logic [1:0]           RespSlverr = 2'b10;
    localparam logic [DataWidth-1:0] ErrorData  = 32'hDEAD_BEEF;

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------
    // ID 0 is reserved for "no interrupt"
    localparam int NumSources = 4;
    localparam int SrcIdWidth = 2;
    localparam int NumTimers  = 2;
    localparam int GpioWidth  = 8;

    localparam logic [OffsetWidth-1:0] IrqEnableOff  = 12'h000;
    localparam logic [OffsetWidth-1:0] IrqPendingOff = 12'h004;
    localparam logic [OffsetWidth-1:0] IrqClaimOff   = 12'h008;

    // Timer n sits at n * TmrStride
    localparam int                     TmrStride   = 'h10;
    localparam logic [OffsetWidth-1:0] TmrCountOff = 12'h000;
    localparam logic [OffsetWidth-1:0] TmrCtrlOff  = 12'h004;
    localparam logic [OffsetWidth-1:0] TmrCmpOff   = 12'h008;

    localparam logic [OffsetWidth-1:0] GpioLedOff = 12'h000;
    localparam logic [OffsetWidth-1:0] GpioDipOff = 12'h004;

endpackage

// File: design/periph_bus_ctrl.sv
`timescale 1ns/1ns
// AXI4-Lite slave front end of the peripheral block
// Decodes the region and hands single-cycle register strobes to the blocks

module periph_bus_ctrl (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic [periph_pkg::AddrWidth-1:0]     awaddr_i,
    input  logic                                 awvalid_i,
    output logic                                 awready_o,
    input  logic [periph_pkg::DataWidth-1:0]     wdata_i,
    input  logic [periph_pkg::DataWidth/8-1:0]   wstrb_i,
    input  logic                                 wvalid_i,
    output logic                                 wready_o,
    output logic [1:0]                           bresp_o,
    output logic                                 bvalid_o,
    input  logic                                 bready_i,
    input  logic [periph_pkg::AddrWidth-1:0]     araddr_i,
    input  logic                                 arvalid_i,
    output logic                                 arready_o,
    output logic [periph_pkg::DataWidth-1:0]     rdata_o,
    output logic [1:0]                           rresp_o,
    output logic                                 rvalid_o,
    input  logic                                 rready_i,
    input  logic [periph_pkg::DataWidth-1:0]     rdata_irq_i,
    input  logic [periph_pkg::DataWidth-1:0]     rdata_tmr_i,
    input  logic [periph_pkg::DataWidth-1:0]     rdata_gpio_i,
    output logic [periph_pkg::OffsetWidth-1:0]   reg_off_o,
    output logic [periph_pkg::DataWidth-1:0]     reg_wdata_o,
    output logic [periph_pkg::DataWidth/8-1:0]   reg_wstrb_o,
    output logic                                 irq_we_o,
    output logic                                 irq_re_o,
    output logic                                 tmr_we_o,
    output logic                                 tmr_re_o,
    output logic                                 gpio_we_o,
    output logic                                 gpio_re_o
);
    import periph_pkg::*;

    logic                         aw_fire;
    logic                         ar_fire;
    logic [RegionMsb-RegionLsb:0] wr_region;
    logic [RegionMsb-RegionLsb:0] rd_region;
    logic                         wr_mapped;
    logic [DataWidth-1:0]         rd_data;
    logic [1:0]                   rd_resp;

    // ------------------------------------------------------------------------
    // Handshake and decode
    // ------------------------------------------------------------------------
    // AW and W are taken together, and a write wins the shared offset
    assign aw_fire   = awvalid_i && wvalid_i && !bvalid_o;
    assign ar_fire   = arvalid_i && !rvalid_o && !aw_fire;
    assign awready_o = aw_fire;
    assign wready_o  = aw_fire;
    assign arready_o = ar_fire;

    assign wr_region = awaddr_i[RegionMsb:RegionLsb];
    assign rd_region = araddr_i[RegionMsb:RegionLsb];
    assign wr_mapped = wr_region inside {RegionIrq, RegionTimer, RegionGpio};

    assign reg_off_o   = aw_fire ? awaddr_i[OffsetWidth-1:0] : araddr_i[OffsetWidth-1:0];
    assign reg_wdata_o = wdata_i;
    assign reg_wstrb_o = wstrb_i;

    assign irq_we_o  = aw_fire && (wr_region == RegionIrq);
    assign tmr_we_o  = aw_fire && (wr_region == RegionTimer);
    assign gpio_we_o = aw_fire && (wr_region == RegionGpio);
    assign irq_re_o  = ar_fire && (rd_region == RegionIrq);
    assign tmr_re_o  = ar_fire && (rd_region == RegionTimer);
    assign gpio_re_o = ar_fire && (rd_region == RegionGpio);

    always_comb begin
        rd_resp = RespOkay;
        case (rd_region)
            RegionIrq:   rd_data = rdata_irq_i;
            RegionTimer: rd_data = rdata_tmr_i;
            RegionGpio:  rd_data = rdata_gpio_i;
            default: begin
                rd_data = ErrorData;
                rd_resp = RespSlverr;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Response channels
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (aw_fire) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (ar_fire) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            bresp_o <= wr_mapped ? RespOkay : RespSlverr;
        end
        if (ar_fire) begin
            rdata_o <= rd_data;
            rresp_o <= rd_resp;
        end
    end

endmodule

// File: design/irq_ctrl.sv
`timescale 1ns/1ns
// Interrupt controller for a single target
// Level gateways, enable mask and claim/complete with lowest ID first

module irq_ctrl (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               we_i,
    input  logic                               re_i,
    input  logic [periph_pkg::OffsetWidth-1:0] off_i,
    input  logic [periph_pkg::DataWidth-1:0]   wdata_i,
    input  logic [periph_pkg::NumTimers-1:0]   tmr_irq_i,
    input  logic                               ext_irq_i,
    output logic [periph_pkg::DataWidth-1:0]   rdata_o,
    output logic                               irq_o
);
    import periph_pkg::*;

    logic [NumSources-1:0] src;
    logic [NumSources-1:0] enable_q;
    logic [NumSources-1:0] pending_q;
    logic [NumSources-1:0] in_service_q;
    logic [NumSources-1:0] pending_d;
    logic [NumSources-1:0] in_service_d;
    logic [SrcIdWidth-1:0] claim_id;
    logic                  claim_rd;
    logic                  complete_wr;

    // ID 0 never fires
    assign src = {ext_irq_i, tmr_irq_i, 1'b0};

    assign claim_rd    = re_i && (off_i == IrqClaimOff);
    assign complete_wr = we_i && (off_i == IrqClaimOff);

    // Scan downwards so the lowest ID is left standing
    always_comb begin
        claim_id = '0;
        for (int i = NumSources - 1; i > 0; i--) begin
            if (enable_q[i] && pending_q[i]) begin
                claim_id = SrcIdWidth'(i);
            end
        end
    end

    // Gateway latch first, then claim and complete
    always_comb begin
        pending_d    = pending_q | (src & ~in_service_q);
        in_service_d = in_service_q;
        if (complete_wr) begin
            in_service_d[wdata_i[SrcIdWidth-1:0]] = 1'b0;
        end
        if (claim_rd && claim_id != '0) begin
            pending_d[claim_id]    = 1'b0;
            in_service_d[claim_id] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            irq_o        <= 1'b0;
        end else begin
            if (we_i && off_i == IrqEnableOff) begin
                enable_q <= {wdata_i[NumSources-1:1], 1'b0};
            end
            pending_q    <= pending_d;
            in_service_q <= in_service_d;
            irq_o        <= |(pending_q & enable_q);
        end
    end

    always_comb begin
        case (off_i)
            IrqEnableOff:  rdata_o = DataWidth'(enable_q);
            IrqPendingOff: rdata_o = DataWidth'(pending_q);
            IrqClaimOff:   rdata_o = DataWidth'(claim_id);
            default:       rdata_o = '0;
        endcase
    end

endmodule

// File: design/cmp_timer.sv
`timescale 1ns/1ns
// Compare timers with sticky match flags
// Each count wraps to zero on match and raises its interrupt flag

module cmp_timer (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   we_i,
    input  logic                                   re_i,
    input  logic [periph_pkg::OffsetWidth-1:0]     off_i,
    input  logic [periph_pkg::DataWidth-1:0]       wdata_i,
    output logic [periph_pkg::DataWidth-1:0]       rdata_o,
    output logic [periph_pkg::NumTimers-1:0]       match_o
);
    import periph_pkg::*;

    logic [DataWidth-1:0] count_q [NumTimers];
    logic [DataWidth-1:0] cmp_q   [NumTimers];
    logic [NumTimers-1:0] en_q;
    logic [NumTimers-1:0] flag_q;
    logic [NumTimers-1:0] hit;

    function automatic logic [OffsetWidth-1:0] reg_addr(input int n,
                                                        input logic [OffsetWidth-1:0] off);
        return OffsetWidth'(n * TmrStride) + off;
    endfunction

    always_comb begin
        for (int n = 0; n < NumTimers; n++) begin
            hit[n] = en_q[n] && (count_q[n] == cmp_q[n]);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int n = 0; n < NumTimers; n++) begin
            if (!rst_n_i) begin
                count_q[n] <= '0;
                en_q[n]    <= 1'b0;
                flag_q[n]  <= 1'b0;
            end else begin
                if (we_i && off_i == reg_addr(n, TmrCountOff)) begin
                    count_q[n] <= wdata_i;
                end else if (hit[n]) begin
                    count_q[n] <= '0;
                end else if (en_q[n]) begin
                    count_q[n] <= count_q[n] + 1'b1;
                end
                // A control write always clears the flag
                if (we_i && off_i == reg_addr(n, TmrCtrlOff)) begin
                    en_q[n]   <= wdata_i[0];
                    flag_q[n] <= 1'b0;
                end else if (hit[n]) begin
                    flag_q[n] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int n = 0; n < NumTimers; n++) begin
            if (we_i && off_i == reg_addr(n, TmrCmpOff)) begin
                cmp_q[n] <= wdata_i;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int n = 0; n < NumTimers; n++) begin
            if (re_i && off_i == reg_addr(n, TmrCountOff)) begin
                rdata_o = count_q[n];
            end
            if (re_i && off_i == reg_addr(n, TmrCtrlOff)) begin
                rdata_o = DataWidth'({flag_q[n], en_q[n]});
            end
            if (re_i && off_i == reg_addr(n, TmrCmpOff)) begin
                rdata_o = cmp_q[n];
            end
        end
    end

    assign match_o = flag_q;

endmodule

// File: design/gpio_regs.sv
`timescale 1ns/1ns
// GPIO registers, LED outputs and synchronized DIP switch inputs

module gpio_regs (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 we_i,
    input  logic [periph_pkg::OffsetWidth-1:0]   off_i,
    input  logic [periph_pkg::DataWidth-1:0]     wdata_i,
    input  logic [periph_pkg::DataWidth/8-1:0]   wstrb_i,
    input  logic [periph_pkg::GpioWidth-1:0]     dip_switches_i,
    output logic [periph_pkg::DataWidth-1:0]     rdata_o,
    output logic [periph_pkg::GpioWidth-1:0]     leds_o
);
    import periph_pkg::*;

    logic [GpioWidth-1:0] dip_meta;
    logic [GpioWidth-1:0] dip_sync;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            leds_o <= '0;
        end else if (we_i && off_i == GpioLedOff && wstrb_i[0]) begin
            leds_o <= wdata_i[GpioWidth-1:0];
        end
    end

    // Two-flop synchronizer
    always_ff @(posedge clk_i) begin
        dip_meta <= dip_switches_i;
        dip_sync <= dip_meta;
    end

    always_comb begin
        case (off_i)
            GpioLedOff: rdata_o = DataWidth'(leds_o);
            GpioDipOff: rdata_o = DataWidth'(dip_sync);
            default:    rdata_o = '0;
        endcase
    end

endmodule

// File: design/periph_top.sv
`timescale 1ns/1ns
// Peripheral top level
// One AXI4-Lite port in front of the interrupt controller, timers and GPIO

module periph_top (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic [periph_pkg::AddrWidth-1:0]     awaddr_i,
    input  logic                                 awvalid_i,
    output logic                                 awready_o,
    input  logic [periph_pkg::DataWidth-1:0]     wdata_i,
    input  logic [periph_pkg::DataWidth/8-1:0]   wstrb_i,
    input  logic                                 wvalid_i,
    output logic                                 wready_o,
    output logic [1:0]                           bresp_o,
    output logic                                 bvalid_o,
    input  logic                                 bready_i,
    input  logic [periph_pkg::AddrWidth-1:0]     araddr_i,
    input  logic                                 arvalid_i,
    output logic                                 arready_o,
    output logic [periph_pkg::DataWidth-1:0]     rdata_o,
    output logic [1:0]                           rresp_o,
    output logic                                 rvalid_o,
    input  logic                                 rready_i,
    input  logic                                 ext_irq_i,
    input  logic [periph_pkg::GpioWidth-1:0]     dip_switches_i,
    output logic [periph_pkg::GpioWidth-1:0]     leds_o,
    output logic                                 irq_o
);
    import periph_pkg::*;

    logic [OffsetWidth-1:0] reg_off;
    logic [DataWidth-1:0]   reg_wdata;
    logic [DataWidth/8-1:0] reg_wstrb;
    logic                   irq_we;
    logic                   irq_re;
    logic                   tmr_we;
    logic                   tmr_re;
    logic                   gpio_we;
    logic [DataWidth-1:0]   rdata_irq;
    logic [DataWidth-1:0]   rdata_tmr;
    logic [DataWidth-1:0]   rdata_gpio;
    logic [NumTimers-1:0]   tmr_match;

    periph_bus_ctrl u_bus_ctrl (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .awaddr_i     ( awaddr_i     ),
        .awvalid_i    ( awvalid_i    ),
        .awready_o    ( awready_o    ),
        .wdata_i      ( wdata_i      ),
        .wstrb_i      ( wstrb_i      ),
        .wvalid_i     ( wvalid_i     ),
        .wready_o     ( wready_o     ),
        .bresp_o      ( bresp_o      ),
        .bvalid_o     ( bvalid_o     ),
        .bready_i     ( bready_i     ),
        .araddr_i     ( araddr_i     ),
        .arvalid_i    ( arvalid_i    ),
        .arready_o    ( arready_o    ),
        .rdata_o      ( rdata_o      ),
        .rresp_o      ( rresp_o      ),
        .rvalid_o     ( rvalid_o     ),
        .rready_i     ( rready_i     ),
        .rdata_irq_i  ( rdata_irq    ),
        .rdata_tmr_i  ( rdata_tmr    ),
        .rdata_gpio_i ( rdata_gpio   ),
        .reg_off_o    ( reg_off      ),
        .reg_wdata_o  ( reg_wdata    ),
        .reg_wstrb_o  ( reg_wstrb    ),
        .irq_we_o     ( irq_we       ),
        .irq_re_o     ( irq_re       ),
        .tmr_we_o     ( tmr_we       ),
        .tmr_re_o     ( tmr_re       ),
        .gpio_we_o    ( gpio_we      ),
        // GPIO reads have no side effects
        .gpio_re_o    (              )
    );

    irq_ctrl u_irq_ctrl (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .we_i      ( irq_we    ),
        .re_i      ( irq_re    ),
        .off_i     ( reg_off   ),
        .wdata_i   ( reg_wdata ),
        .tmr_irq_i ( tmr_match ),
        .ext_irq_i ( ext_irq_i ),
        .rdata_o   ( rdata_irq ),
        .irq_o     ( irq_o     )
    );

    cmp_timer u_cmp_timer (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .we_i    ( tmr_we    ),
        .re_i    ( tmr_re    ),
        .off_i   ( reg_off   ),
        .wdata_i ( reg_wdata ),
        .rdata_o ( rdata_tmr ),
        .match_o ( tmr_match )
    );

    gpio_regs u_gpio_regs (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .we_i           ( gpio_we        ),
        .off_i          ( reg_off        ),
        .wdata_i        ( reg_wdata      ),
        .wstrb_i        ( reg_wstrb      ),
        .dip_switches_i ( dip_switches_i ),
        .rdata_o        ( rdata_gpio     ),
        .leds_o         ( leds_o         )
    );

endmodule

// File: test/periph_assert.sv
`timescale 1ns/1ns
// AXI4-Lite handshake checks, bound into the peripheral top level

module periph_assert (
    input logic                             clk_i,
    input logic                             rst_n_i,
    input logic                             awready_o,
    input logic                             bvalid_o,
    input logic [1:0]                       bresp_o,
    input logic                             bready_i,
    input logic                             rvalid_o,
    input logic [periph_pkg::DataWidth-1:0] rdata_o,
    input logic                             rready_i
);

    // Failed checks so far
    int error_count = 0;

    // B channel holds until the master takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else begin
        error_count++;
        $error("bvalid or bresp changed while bready was low");
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
    else begin
        error_count++;
        $error("rvalid or rdata changed while rready was low");
    end

    // No new write while a response waits
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(awready_o && bvalid_o))
    else begin
        error_count++;
        $error("awready was high while bvalid was pending");
    end

endmodule

bind periph_top periph_assert u_assert (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .awready_o ( awready_o ),
    .bvalid_o  ( bvalid_o  ),
    .bresp_o   ( bresp_o   ),
    .bready_i  ( bready_i  ),
    .rvalid_o  ( rvalid_o  ),
    .rdata_o   ( rdata_o   ),
    .rready_i  ( rready_i  )
);

// File: test/tb_periph_top.sv
`timescale 1ns/1ns
// Testbench for the peripheral top level
// Replays the golden operation file over AXI4-Lite with random response back-pressure

module tb_periph_top;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic [15:0] awaddr_i;
    logic        awvalid_i;
    logic        awready_o;
    logic [31:0] wdata_i;
    logic [3:0]  wstrb_i;
    logic        wvalid_i;
    logic        wready_o;
    logic [1:0]  bresp_o;
    logic        bvalid_o;
    logic        bready_i;
    logic [15:0] araddr_i;
    logic        arvalid_i;
    logic        arready_o;
    logic [31:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        rvalid_o;
    logic        rready_i;
    logic        ext_irq_i;
    logic [7:0]  dip_switches_i;
    logic [7:0]  leds_o;
    logic        irq_o;

    logic [31:0] lcg_state = 32'h3397a50c;
    int          cycle_count;
    int          cycle_limit = 100000;
    byte         op_q[$];
    logic [31:0] a_q[$];
    logic [31:0] b_q[$];
    logic [31:0] c_q[$];

    periph_top u_dut (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // Random hold-off of 0 to 3 cycles before a ready
    task automatic random_wait();
        logic [31:0] r;
        r = lcg_next();
        repeat (r[17:16]) @(negedge clk_i);
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk_i);
        awaddr_i  = addr;
        wdata_i   = data;
        wstrb_i   = 4'hf;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        // The previous B is released only now, so the new AW waits behind it
        if (bvalid_o) begin
            random_wait();
            bready_i = 1'b1;
            @(negedge clk_i);
            bready_i = 1'b0;
        end
        do @(posedge clk_i); while (!awready_o);
        check_value("wready_o", 32'(wready_o), 32'h1);
        @(negedge clk_i);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        check_value("bvalid_o", 32'(bvalid_o), 32'h1);
        resp = bresp_o;
    endtask

    task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk_i);
        araddr_i  = addr;
        arvalid_i = 1'b1;
        do @(posedge clk_i); while (!arready_o);
        @(negedge clk_i);
        arvalid_i = 1'b0;
        check_value("rvalid_o", 32'(rvalid_o), 32'h1);
        data = rdata_o;
        resp = rresp_o;
        random_wait();
        rready_i = 1'b1;
        @(negedge clk_i);
        rready_i = 1'b0;
    endtask

    task automatic poll_bit(input logic [15:0] addr, input logic [4:0] bit_idx);
        logic [31:0] data;
        logic [1:0]  resp;
        data = '0;
        while (!data[bit_idx]) begin
            axi_read(addr, data, resp);
            check_value("rresp", 32'(resp), 32'h0);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          code;
        bit          done;
        bit          bad;
        byte         op;
        string       tok;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("test/periph_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file test/periph_golden.txt");
            $display("Simulation FAILED");
            $fatal(1);
        end
        done = 1'b0;
        bad  = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok.getc(0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                op = tok.getc(0);
                a  = '0;
                b  = '0;
                c  = '0;
                case (op)
                    "W", "R":          code = $fscanf(fd, "%h %h %h", a, b, c);
                    "P":               code = $fscanf(fd, "%h %h", a, b);
                    "E", "D", "I", "L": code = $fscanf(fd, "%h", a);
                    default:           bad = 1'b1;
                endcase
                if (bad) begin
                    $display("Unknown operation %s in the golden file", tok);
                    $display("Simulation FAILED");
                    $fatal(1);
                end else begin
                    op_q.push_back(op);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_op(input int i);
        logic [31:0] data;
        logic [1:0]  resp;
        case (op_q[i])
            "W": begin
                axi_write(a_q[i][15:0], b_q[i], resp);
                check_value("bresp", 32'(resp), c_q[i]);
            end
            "R": begin
                axi_read(a_q[i][15:0], data, resp);
                check_value("rdata", data, b_q[i]);
                check_value("rresp", 32'(resp), c_q[i]);
            end
            "E": begin
                @(negedge clk_i);
                ext_irq_i = a_q[i][0];
            end
            "D": begin
                @(negedge clk_i);
                dip_switches_i = a_q[i][7:0];
                // Let the value through the synchronizer
                repeat (3) @(negedge clk_i);
            end
            "I": begin
                repeat (2) @(negedge clk_i);
                check_value("irq_o", 32'(irq_o), a_q[i]);
            end
            "L": begin
                @(negedge clk_i);
                check_value("leds_o", 32'(leds_o), a_q[i]);
            end
            "P": poll_bit(a_q[i][15:0], b_q[i][4:0]);
            default: ;
        endcase
    endtask

    // Stop at the first failed handshake assertion
    always @(negedge clk_i) begin
        if (u_dut.u_assert.error_count != 0) begin
            $display("A bound AXI4-Lite handshake assertion failed");
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin : main
        rst_n_i        = 1'b0;
        awaddr_i       = '0;
        awvalid_i      = 1'b0;
        wdata_i        = '0;
        wstrb_i        = '0;
        wvalid_i       = 1'b0;
        bready_i       = 1'b0;
        araddr_i       = '0;
        arvalid_i      = 1'b0;
        rready_i       = 1'b0;
        ext_irq_i      = 1'b0;
        dip_switches_i = '0;
        load_golden();
        cycle_limit = 40 * op_q.size() + 2000;
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            run_op(i);
        end
        @(negedge clk_i);
        if (u_dut.u_assert.error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("A bound AXI4-Lite handshake assertion failed");
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

// File: periph_top.f
design/periph_pkg.sv
design/periph_bus_ctrl.sv
design/irq_ctrl.sv
design/cmp_timer.sv
design/gpio_regs.sv
design/periph_top.sv
test/periph_assert.sv
test/tb_periph_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_periph_top -f periph_top.f -o sim_periph \
    && ./obj_dir/sim_periph > sim.log 2>&1 \
    || echo "Build or run ended with an error"
cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }

// File: test/periph_golden.txt
# W addr data resp | R addr data resp | P addr bit | E ext_irq | D dip | I irq_o | L leds_o
# All fields in hex, one operation per line
W 2000 0000005a 0
L 5a
R 2000 0000005a 0
D a5
R 2004 000000a5 0
W 5000 000000ff 2
L 5a
R 5000 deadbeef 2
W 0000 00000008 0
E 1
I 1
R 0004 00000008 0
R 0008 00000003 0
I 0
E 0
W 0008 00000003 0
R 0008 00000000 0
W 1008 00000014 0
W 0000 00000002 0
W 1004 00000001 0
P 0004 1
R 0008 00000001 0
W 1004 00000000 0
R 1004 00000000 0
W 0008 00000001 0
R 0008 00000000 0
W 0000 0000000a 0
E 1
W 1000 00000000 0
W 1004 00000001 0
P 0004 1
R 0004 0000000a 0
R 0008 00000001 0
R 0008 00000003 0
R 0008 00000000 0
W 1004 00000000 0
E 0
W 0008 00000001 0
W 0008 00000003 0
R 0008 00000000 0
